//--- Makefile
TOOL       := verilator
FLAGS      := --binary --assert --timing --timescale 1ns/100ps
LINT_FLAGS := --lint-only --assert --timing --timescale 1ns/100ps -Wall
TOP        := commit_tb
FILELIST   := commit.f
OBJ_DIR    := obj_dir
SIM_ARGS   := +verilator+error+limit+1000
PASS_MSG   := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- commit.f
verilog/commit_pkg.sv
verilog/stream_arb.sv
verilog/commit_accounting.sv
verilog/commit_unit.sv
verification/commit_checker.sv
verification/commit_monitor.sv
verification/commit_tb.sv

//--- verification/commit_checker.sv
/*
 * Protocol assertions on the execution-unit streams and the writeback port
 */
module commit_checker (
    input logic                                                         clk,
    input logic                                                         reset,
    input logic [commit_pkg::NUM_EX_UNITS*commit_pkg::ISSUE_WIDTH-1:0]  commit_valid,
    input commit_pkg::commit_data_t                                     commit_data
                                        [commit_pkg::NUM_EX_UNITS*commit_pkg::ISSUE_WIDTH],
    input logic [commit_pkg::NUM_EX_UNITS*commit_pkg::ISSUE_WIDTH-1:0]  commit_ready,
    input logic [commit_pkg::ISSUE_WIDTH-1:0]                           wb_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import commit_pkg::*;

    localparam int NUM_STREAMS = NUM_EX_UNITS * ISSUE_WIDTH;

    int assert_failures = 0;

    for (genvar i = 0; i < NUM_STREAMS; i++) begin : g_stream
        // Producer holds its payload until the transfer
        a_hold: assert property (@(posedge clk) disable iff (reset)
            commit_valid[i] && !commit_ready[i] |=> $stable(commit_data[i]))
        else begin
            $error("stream %0d changed its payload while stalled", i);
            assert_failures++;
        end

        a_ready_valid: assert property (@(posedge clk) disable iff (reset)
            commit_ready[i] |-> commit_valid[i])
        else begin
            $error("stream %0d got ready without valid", i);
            assert_failures++;
        end
    end

    for (genvar s = 0; s < ISSUE_WIDTH; s++) begin : g_slot
        logic [NUM_EX_UNITS-1:0] slot_ready;

        for (genvar u = 0; u < NUM_EX_UNITS; u++) begin : g_unit
            assign slot_ready[u] = commit_ready[u * ISSUE_WIDTH + s];
        end

        // One grant per slot
        a_one_ready: assert property (@(posedge clk) disable iff (reset)
            $onehot0(slot_ready))
        else begin
            $error("slot %0d granted more than one unit", s);
            assert_failures++;
        end
    end

    // Output register is cleared by the first reset edge
    a_wb_reset: assert property (@(posedge clk) reset |=> wb_valid == '0)
    else begin
        $error("writeback valid during reset");
        assert_failures++;
    end

endmodule

//--- verification/commit_monitor.sv
/*
 * Commit stage monitor: reference model of the writeback, warp mask and
 * instret outputs, compared against the DUT on every clock edge
 */
module commit_monitor #(
    parameter int NUM_INSTR = 2000
) (
    input  logic                                                        clk,
    input  logic                                                        reset,
    input  logic [commit_pkg::NUM_EX_UNITS*commit_pkg::ISSUE_WIDTH-1:0] commit_valid,
    input  commit_pkg::commit_data_t                                    commit_data
                                        [commit_pkg::NUM_EX_UNITS*commit_pkg::ISSUE_WIDTH],
    input  logic [commit_pkg::NUM_EX_UNITS*commit_pkg::ISSUE_WIDTH-1:0] commit_ready,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0]                          wb_valid,
    input  commit_pkg::writeback_data_t                                 wb_data
                                                                [commit_pkg::ISSUE_WIDTH],
    input  logic [commit_pkg::PERF_CTR_BITS-1:0]                        instret,
    input  logic [commit_pkg::NUM_WARPS-1:0]                            committed_warps,
    input  logic                                                        end_check,
    output int                                                          error_count,
    output logic                                                        final_done
);
    timeunit 1ns;
    timeprecision 100ps;
    import commit_pkg::*;

    localparam int NUM_STREAMS = NUM_EX_UNITS * ISSUE_WIDTH;

    // Expected writeback of every slot for one cycle
    typedef struct packed {
        logic [ISSUE_WIDTH-1:0]             valid;
        writeback_data_t [ISSUE_WIDTH-1:0]  data;
    } wb_expect_t;

    wb_expect_t                     wb_q[$];
    logic [NUM_WARPS-1:0]           warp_q[$];
    logic [COMMIT_ALL_SIZEW-1:0]    lanes_q[$];
    logic [PERF_CTR_BITS-1:0]       exp_instret;
    logic [PERF_CTR_BITS-1:0]       total_lanes;
    int                             errors = 0;
    int                             wb_count = 0;
    int                             nowb_count = 0;
    bit                             was_reset = 1'b0;
    bit                             done = 1'b0;

    assign error_count = errors;
    assign final_done  = done;

    // Writeback port contents for a committed instruction
    function automatic writeback_data_t expected_wb(input commit_data_t c);
        writeback_data_t w;
        w.uuid  = c.uuid;
        w.wis   = WIS_WIDTH'(c.wid / ISSUE_WIDTH);
        w.PC    = c.PC;
        w.tmask = c.tmask;
        w.rd    = c.rd;
        w.data  = c.data;
        w.sop   = c.sop;
        w.eop   = c.eop;
        return w;
    endfunction

    function automatic int lane_count(input logic [NUM_THREADS-1:0] mask);
        int count;
        count = 0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            count = count + int'(mask[t]);
        end
        return count;
    endfunction

    // First valid unit of each slot gets ready
    function automatic logic [NUM_STREAMS-1:0] expected_ready(
        input logic [NUM_STREAMS-1:0] valid
    );
        logic [NUM_STREAMS-1:0] ready;
        logic                   found;
        ready = '0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            found = 1'b0;
            for (int u = 0; u < NUM_EX_UNITS; u++) begin
                if (!found && valid[u * ISSUE_WIDTH + s]) begin
                    ready[u * ISSUE_WIDTH + s] = 1'b1;
                    found = 1'b1;
                end
            end
        end
        return ready;
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] expected,
                                   input logic [255:0] got);
        $display("Mismatch %s: expected %0h, got %0h", name, expected, got);
        errors++;
    endtask

    always @(posedge clk) begin
        wb_expect_t             wb_now;
        wb_expect_t             wb_exp;
        logic [NUM_WARPS-1:0]   warps_now;
        logic [NUM_WARPS-1:0]   warps_exp;
        int                     lanes_now;
        int                     s;

        if (reset) begin
            if (was_reset) begin
                if (commit_ready != '0) begin
                    report_mismatch("commit_ready", 256'(0), 256'(commit_ready));
                end
                if (instret != '0) begin
                    report_mismatch("instret", 256'(0), 256'(instret));
                end
                if (committed_warps != '0) begin
                    report_mismatch("committed_warps", 256'(0), 256'(committed_warps));
                end
            end
            was_reset   = 1'b1;
            exp_instret = '0;
            total_lanes = '0;
            // Empty pipeline, one entry per cycle of latency
            wb_q.delete();
            warp_q.delete();
            lanes_q.delete();
            wb_q.push_back('0);
            repeat (2) warp_q.push_back('0);
            repeat (4) lanes_q.push_back('0);
        end else begin
            if (commit_ready != expected_ready(commit_valid)) begin
                report_mismatch("commit_ready", 256'(expected_ready(commit_valid)),
                                256'(commit_ready));
            end

            // Transfers of this cycle
            wb_now    = '0;
            warps_now = '0;
            lanes_now = 0;
            for (int i = 0; i < NUM_STREAMS; i++) begin
                if (commit_valid[i] && commit_ready[i]) begin
                    s = i % ISSUE_WIDTH;
                    wb_now.valid[s] = commit_data[i].wb;
                    wb_now.data[s]  = expected_wb(commit_data[i]);
                    if (commit_data[i].eop) begin
                        warps_now[commit_data[i].wid] = 1'b1;
                    end
                    if (!commit_data[i].wb) begin
                        nowb_count++;
                    end
                    lanes_now += lane_count(commit_data[i].tmask);
                end
            end

            // Writeback, one cycle behind
            wb_exp = wb_q.pop_front();
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (wb_valid[k]) begin
                    wb_count++;
                end
                if (wb_valid[k] != wb_exp.valid[k]) begin
                    report_mismatch($sformatf("wb_valid[%0d]", k), 256'(wb_exp.valid[k]),
                                    256'(wb_valid[k]));
                end else if (wb_valid[k] && wb_data[k] != wb_exp.data[k]) begin
                    report_mismatch($sformatf("wb_data[%0d]", k), 256'(wb_exp.data[k]),
                                    256'(wb_data[k]));
                end
            end

            // Warp mask two cycles behind, instret four
            warps_exp = warp_q.pop_front();
            if (committed_warps != warps_exp) begin
                report_mismatch("committed_warps", 256'(warps_exp), 256'(committed_warps));
            end
            exp_instret = exp_instret + PERF_CTR_BITS'(lanes_q.pop_front());
            if (instret != exp_instret) begin
                report_mismatch("instret", 256'(exp_instret), 256'(instret));
            end

            wb_q.push_back(wb_now);
            warp_q.push_back(warps_now);
            lanes_q.push_back(COMMIT_ALL_SIZEW'(lanes_now));
            total_lanes = total_lanes + PERF_CTR_BITS'(lanes_now);

            if (end_check && !done) begin
                if (wb_count + nowb_count != NUM_INSTR) begin
                    report_mismatch("commit_count", 256'(NUM_INSTR),
                                    256'(wb_count + nowb_count));
                end
                if (instret != total_lanes) begin
                    report_mismatch("instret", 256'(total_lanes), 256'(instret));
                end
                done <= 1'b1;
            end
        end
    end

endmodule

//--- verification/commit_tb.sv
/*
 * Testbench top for the commit stage: clock, reset, random results
 * from the execution units, watchdog and closing report
 */
module commit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import commit_pkg::*;

    localparam int NUM_STREAMS    = NUM_EX_UNITS * ISSUE_WIDTH;
    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * NUM_EX_UNITS * 4 + 100;

    logic                       clk;
    logic                       reset = 1'b1;
    logic [NUM_STREAMS-1:0]     commit_valid = '0;
    commit_data_t               commit_data [NUM_STREAMS] = '{default: '0};
    logic [NUM_STREAMS-1:0]     commit_ready;
    logic [ISSUE_WIDTH-1:0]     wb_valid;
    writeback_data_t            wb_data [ISSUE_WIDTH];
    logic [PERF_CTR_BITS-1:0]   instret;
    logic [NUM_WARPS-1:0]       committed_warps;
    logic                       end_check = 1'b0;
    int                         mon_errors;
    logic                       final_done;

    logic [31:0]                lfsr = 32'd32;
    logic [NUM_STREAMS-1:0]     next_sop = '1;
    int                         issued = 0;
    int                         transferred = 0;

    commit_unit dut (
        .clk             (clk),
        .reset           (reset),
        .commit_valid    (commit_valid),
        .commit_data     (commit_data),
        .commit_ready    (commit_ready),
        .wb_valid        (wb_valid),
        .wb_data         (wb_data),
        .instret         (instret),
        .committed_warps (committed_warps)
    );

    commit_monitor #(
        .NUM_INSTR (NUM_INSTR)
    ) mon (
        .clk             (clk),
        .reset           (reset),
        .commit_valid    (commit_valid),
        .commit_data     (commit_data),
        .commit_ready    (commit_ready),
        .wb_valid        (wb_valid),
        .wb_data         (wb_data),
        .instret         (instret),
        .committed_warps (committed_warps),
        .end_check       (end_check),
        .error_count     (mon_errors),
        .final_done      (final_done)
    );

    bind commit_unit commit_checker chk (
        .clk          (clk),
        .reset        (reset),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_ready (commit_ready),
        .wb_valid     (wb_valid)
    );

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic commit_data_t make_instruction(input int stream);
        commit_data_t c;
        int           slot;
        slot    = stream % ISSUE_WIDTH;
        c.uuid  = UUID_WIDTH'(issued);
        // Warp always maps to this stream's slot
        c.wid   = NW_WIDTH'(slot + ISSUE_WIDTH * (issued % (NUM_WARPS / ISSUE_WIDTH)));
        c.PC    = PC_BITS'(32'h400 + issued * 4);
        c.wb    = 1'(random_bits(1));
        c.tmask = NUM_THREADS'(random_bits(NUM_THREADS));
        c.rd    = NR_BITS'(random_bits(NR_BITS));
        for (int t = 0; t < NUM_THREADS; t++) begin
            c.data[t] = random_bits(XLEN);
        end
        c.sop   = next_sop[stream];
        c.eop   = 1'(random_bits(1));
        next_sop[stream] = c.eop;
        return c;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Idle streams may start new instructions from the first edge on
    always @(posedge clk) begin
        for (int i = 0; i < NUM_STREAMS; i++) begin
            if (commit_valid[i] && commit_ready[i]) begin
                transferred++;
            end
            if (!commit_valid[i] || commit_ready[i]) begin
                if (issued < NUM_INSTR && random_bits(1) == 32'd1) begin
                    commit_data[i]  <= make_instruction(i);
                    commit_valid[i] <= 1'b1;
                    issued++;
                end else begin
                    commit_valid[i] <= 1'b0;
                end
            end
        end
    end

    initial begin
        int total_errors;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        wait (transferred == NUM_INSTR);
        // Instret settles four cycles after the last transfer
        repeat (5) @(posedge clk);
        end_check <= 1'b1;
        wait (final_done);
        total_errors = mon_errors + dut.chk.assert_failures;
        $display("Closing report: %0d mismatches, %0d assertion failures",
                 mon_errors, dut.chk.assert_failures);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: only %0d of %0d instructions committed within %0d cycles",
                 transferred, NUM_INSTR, TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

//--- verilog/commit_accounting.sv
/*
 * Commit accounting: pipelined retired-thread counter for the CSR file
 * and a registered mask of warps that finished an instruction
 */
module commit_accounting (
    input  logic                                                    clk,
    input  logic                                                    reset,

    // Per-slot commit info, taken from the arbiter outputs
    input  logic [commit_pkg::ISSUE_WIDTH-1:0]                      slot_fire,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_THREADS-1:0] slot_tmask,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NW_WIDTH-1:0]    slot_wid,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0]                      slot_eop,

    output logic [commit_pkg::PERF_CTR_BITS-1:0]                    instret,
    output logic [commit_pkg::NUM_WARPS-1:0]                        committed_warps
);
    import commit_pkg::*;

    logic                                       fire_any;
    logic [ISSUE_WIDTH-1:0][COMMIT_SIZEW-1:0]   commit_size;
    logic                                       fire_any_r;
    logic [ISSUE_WIDTH-1:0][COMMIT_SIZEW-1:0]   commit_size_r;
    logic [COMMIT_ALL_SIZEW-1:0]                commit_size_all;
    logic                                       fire_any_rr;
    logic [COMMIT_ALL_SIZEW-1:0]                commit_size_all_rr;
    logic [NUM_WARPS-1:0]                       eop_mask;

    // Number of active lanes in a thread mask
    function automatic logic [COMMIT_SIZEW-1:0] popcount(input logic [NUM_THREADS-1:0] bits);
        logic [COMMIT_SIZEW-1:0] count;
        count = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            count = count + COMMIT_SIZEW'(bits[t]);
        end
        return count;
    endfunction

    assign fire_any = |slot_fire;

    // Lanes retired per slot, zero when the slot did not fire
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            commit_size[s] = popcount(slot_tmask[s] & {NUM_THREADS{slot_fire[s]}});
        end
    end

    // Stage 1
    always_ff @(posedge clk) begin
        if (reset) begin
            fire_any_r <= 1'b0;
        end else begin
            fire_any_r <= fire_any;
        end
    end

    always_ff @(posedge clk) begin
        commit_size_r <= commit_size;
    end

    // Sum over slots
    always_comb begin
        commit_size_all = '0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            commit_size_all = commit_size_all + COMMIT_ALL_SIZEW'(commit_size_r[s]);
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        if (reset) begin
            fire_any_rr <= 1'b0;
        end else begin
            fire_any_rr <= fire_any_r;
        end
    end

    always_ff @(posedge clk) begin
        commit_size_all_rr <= commit_size_all;
    end

    // Instret accumulator
    always_ff @(posedge clk) begin
        if (reset) begin
            instret <= '0;
        end else if (fire_any_rr) begin
            instret <= instret + PERF_CTR_BITS'(commit_size_all_rr);
        end
    end

    // Warps whose last micro-op committed this cycle
    always_comb begin
        eop_mask = '0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (slot_fire[s] && slot_eop[s]) begin
                eop_mask[slot_wid[s]] = 1'b1;
            end
        end
    end

    // One-cycle pulse to the scheduler
    always_ff @(posedge clk) begin
        if (reset) begin
            committed_warps <= '0;
        end else begin
            committed_warps <= eop_mask;
        end
    end

endmodule

//--- verilog/commit_pkg.sv
/*
 * Shared sizes and payload types for the SIMT commit stage
 */
package commit_pkg;

    // Core size
    localparam int ISSUE_WIDTH  = 2;
    localparam int NUM_EX_UNITS = 3;    // ALU, FPU, LSU; unit 0 wins
    localparam int NUM_THREADS  = 4;
    localparam int NUM_WARPS    = 4;

    // Index widths
    localparam int NW_WIDTH  = 2;       // warp id
    localparam int WIS_WIDTH = 1;       // warp index within its slot
    localparam int NR_BITS   = 5;       // register index

    // Datapath widths
    localparam int XLEN          = 32;
    localparam int PC_BITS       = 30;
    localparam int UUID_WIDTH    = 8;
    localparam int PERF_CTR_BITS = 44;

    // Lane count of one slot (0..NUM_THREADS)
    localparam int COMMIT_SIZEW = 3;
    // Lane count summed over all slots
    localparam int COMMIT_ALL_SIZEW = 4;

    // Finished instruction from an execution unit
    typedef struct packed {
        logic [UUID_WIDTH-1:0]              uuid;
        logic [NW_WIDTH-1:0]                wid;
        logic [NUM_THREADS-1:0]             tmask;
        logic [PC_BITS-1:0]                 PC;
        logic                               wb;
        logic [NR_BITS-1:0]                 rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]   data;
        logic                               sop;
        logic                               eop;
    } commit_data_t;

    // Register file write port, one per slot
    typedef struct packed {
        logic [UUID_WIDTH-1:0]              uuid;
        logic [WIS_WIDTH-1:0]               wis;
        logic [PC_BITS-1:0]                 PC;
        logic [NUM_THREADS-1:0]             tmask;
        logic [NR_BITS-1:0]                 rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]   data;
        logic                               sop;
        logic                               eop;
    } writeback_data_t;

endpackage

//--- verilog/commit_unit.sv
/*
 * SIMT commit stage: per-slot arbitration of execution-unit results,
 * register-file writeback, instret and committed-warp reporting
 */
module commit_unit (
    input  logic                                    clk,
    input  logic                                    reset,

    // Execution-unit streams, index is unit * ISSUE_WIDTH + slot
    input  logic [commit_pkg::NUM_EX_UNITS*commit_pkg::ISSUE_WIDTH-1:0] commit_valid,
    input  commit_pkg::commit_data_t                commit_data
                                                    [commit_pkg::NUM_EX_UNITS*commit_pkg::ISSUE_WIDTH],
    output logic [commit_pkg::NUM_EX_UNITS*commit_pkg::ISSUE_WIDTH-1:0] commit_ready,

    // Register-file writeback, no back-pressure
    output logic [commit_pkg::ISSUE_WIDTH-1:0]      wb_valid,
    output commit_pkg::writeback_data_t             wb_data [commit_pkg::ISSUE_WIDTH],

    // To CSR file and scheduler
    output logic [commit_pkg::PERF_CTR_BITS-1:0]    instret,
    output logic [commit_pkg::NUM_WARPS-1:0]        committed_warps
);
    import commit_pkg::*;

    logic [ISSUE_WIDTH-1:0]                     arb_valid;
    commit_data_t                               arb_data [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0]                     arb_ready;

    logic [ISSUE_WIDTH-1:0]                     slot_fire;
    logic [ISSUE_WIDTH-1:0][NUM_THREADS-1:0]    slot_tmask;
    logic [ISSUE_WIDTH-1:0][NW_WIDTH-1:0]       slot_wid;
    logic [ISSUE_WIDTH-1:0]                     slot_eop;

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slot
        logic [NUM_EX_UNITS-1:0] valid_in;
        commit_data_t            data_in [NUM_EX_UNITS];
        logic [NUM_EX_UNITS-1:0] ready_in;

        // Gather this slot's streams from every execution unit
        for (genvar j = 0; j < NUM_EX_UNITS; j++) begin : g_unit
            assign valid_in[j] = commit_valid[j * ISSUE_WIDTH + i];
            assign data_in[j]  = commit_data[j * ISSUE_WIDTH + i];
            assign commit_ready[j * ISSUE_WIDTH + i] = ready_in[j];
        end

        stream_arb #(
            .NUM_INPUTS (NUM_EX_UNITS),
            .data_t     (commit_data_t)
        ) u_arb (
            .clk        (clk),
            .reset      (reset),
            .valid_in   (valid_in),
            .data_in    (data_in),
            .ready_in   (ready_in),
            .valid_out  (arb_valid[i]),
            .data_out   (arb_data[i]),
            .ready_out  (arb_ready[i])
        );

        // Writeback always drains
        assign arb_ready[i] = 1'b1;

        assign slot_fire[i]  = arb_valid[i] && arb_ready[i];
        assign slot_tmask[i] = arb_data[i].tmask;
        assign slot_wid[i]   = arb_data[i].wid;
        assign slot_eop[i]   = arb_data[i].eop;

        // Results without a destination register still commit
        assign wb_valid[i] = arb_valid[i] && arb_data[i].wb;

        assign wb_data[i] = '{
            uuid:  arb_data[i].uuid,
            wis:   WIS_WIDTH'(arb_data[i].wid / NW_WIDTH'(ISSUE_WIDTH)),
            PC:    arb_data[i].PC,
            tmask: arb_data[i].tmask,
            rd:    arb_data[i].rd,
            data:  arb_data[i].data,
            sop:   arb_data[i].sop,
            eop:   arb_data[i].eop
        };
    end

    commit_accounting u_accounting (
        .clk             (clk),
        .reset           (reset),
        .slot_fire       (slot_fire),
        .slot_tmask      (slot_tmask),
        .slot_wid        (slot_wid),
        .slot_eop        (slot_eop),
        .instret         (instret),
        .committed_warps (committed_warps)
    );

endmodule

//--- verilog/stream_arb.sv
/*
 * Fixed-priority N-to-1 valid/ready arbiter with a registered output.
 * The lowest-index valid input wins; the output register holds under stall.
 */
module stream_arb #(
    parameter int  NUM_INPUTS = commit_pkg::NUM_EX_UNITS,
    parameter type data_t     = commit_pkg::commit_data_t
) (
    input  logic                  clk,
    input  logic                  reset,

    // Producer side
    input  logic [NUM_INPUTS-1:0] valid_in,
    input  data_t                 data_in [NUM_INPUTS],
    output logic [NUM_INPUTS-1:0] ready_in,

    // Consumer side
    output logic                  valid_out,
    output data_t                 data_out,
    input  logic                  ready_out
);

    logic [NUM_INPUTS-1:0] grant;
    logic                  any_valid;
    logic                  load_en;
    logic                  in_fire;
    data_t                 data_sel;

    // Isolate the lowest set bit of the request vector
    assign grant = valid_in & (~valid_in + NUM_INPUTS'(1));

    assign any_valid = |valid_in;

    // Room for a new entry when out of reset and the register is empty or drained
    assign load_en = !reset && (!valid_out || ready_out);

    // Only the winner sees ready, and only when there is room
    assign ready_in = grant & {NUM_INPUTS{load_en}};

    assign in_fire = |(valid_in & ready_in);

    // Payload of the granted input
    always_comb begin
        data_sel = data_in[0];
        for (int i = 0; i < NUM_INPUTS; i++) begin
            if (grant[i]) begin
                data_sel = data_in[i];
            end
        end
    end

    // Output valid
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (load_en) begin
            // Drops after one cycle unless another input transfers
            valid_out <= any_valid;
        end
    end

    // Output payload, loaded only on an input transfer
    always_ff @(posedge clk) begin
        if (in_fire) begin
            data_out <= data_sel;
        end
    end

endmodule
